/* include/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// datapath and address width
`define XLEN 64

// core-local timer registers
`define CLINT_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define CLINT_MTIME_ADDR    64'h0000_0000_0200_bff8

// machine csr numbers
`define CSR_MSTATUS 12'd768
`define CSR_MIE     12'd772
`define CSR_MTVEC   12'd773
`define CSR_MEPC    12'd833
`define CSR_MCAUSE  12'd834

// mcause values, interrupt flag in the top bit
`define CAUSE_ECALL      64'd11
`define CAUSE_LOAD_FAULT 64'd5
`define CAUSE_TIMER_IRQ  64'h8000_0000_0000_0007

`endif

/* logic/mem_pkg.sv */
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // operation kinds handed over by execute
    typedef enum logic [2:0] {
        op_load        = 3'd0,
        op_clint_store = 3'd1,
        op_csrrw       = 3'd2,
        op_csrrs       = 3'd3,
        op_ecall       = 3'd4,
        op_mret        = 3'd5
    } op_e;

    // load access size
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2,
        size_d = 2'd3
    } size_e;

    // mstatus seen either as a whole csr word or by its interrupt fields
    typedef union packed {
        logic [`XLEN-1:0] raw;
        struct packed {
            logic [`XLEN-9:0] rsvd_hi;
            // previous mie, saved on trap entry
            logic             mpie;
            logic [2:0]       rsvd_mid;
            // global machine interrupt enable
            logic             mie;
            logic [2:0]       rsvd_lo;
        } f;
    } mstatus_u;

endpackage

`default_nettype wire

/* logic/clint_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module clint_timer (
    input  wire              clk,
    input  wire              rst_n,
    // access from the memory stage
    input  wire              mmio_rd,
    input  wire              mmio_wr,
    input  wire              mmio_addr_sel,
    input  wire [`XLEN-1:0]  mmio_wdata,
    output logic [`XLEN-1:0] mmio_rdata,
    // raw compare result, gated later by the csrs
    output logic             timer_pending
);

    logic [`XLEN-1:0] mtime;
    logic [`XLEN-1:0] mtimecmp;

    // free-running time base
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + `XLEN'd1;
        end
    end

    // compare register, parked at max so nothing fires out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (mmio_wr) begin
            mtimecmp <= mmio_wdata;
        end
    end

    assign timer_pending = mtime >= mtimecmp;

    // sel high picks mtime, low picks mtimecmp
    always_comb begin
        if (!mmio_rd) begin
            mmio_rdata = '0;
        end else if (mmio_addr_sel) begin
            mmio_rdata = mtime;
        end else begin
            mmio_rdata = mtimecmp;
        end
    end

endmodule

`default_nettype wire

/* logic/csr_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module csr_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 csr_op_valid,
    input  wire mem_pkg::op_e   csr_op,
    input  wire [11:0]          csr_addr,
    input  wire [`XLEN-1:0]     csr_wdata,
    input  wire [`XLEN-1:0]     trap_pc,
    input  wire                 fault_valid,
    input  wire                 timer_pending,
    output logic [`XLEN-1:0]    csr_rdata,
    output logic [`XLEN-1:0]    trap_target,
    output logic [`XLEN-1:0]    mret_target,
    output logic                irq_take
);

    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mie_q;
    mem_pkg::mstatus_u mstatus_q;

    logic             irq_trap;
    logic             sync_trap;
    logic             do_mret;
    logic             csr_wr_en;
    logic [`XLEN-1:0] csr_wr_val;
    logic [`XLEN-1:0] trap_cause;

    // timer interrupt needs both the global and the mtie enable
    assign irq_take = timer_pending && mstatus_q.f.mie && mie_q[7];

    // old value, returned for csrrw and csrrs
    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS: csr_rdata = mstatus_q.raw;
            `CSR_MIE:     csr_rdata = mie_q;
            `CSR_MTVEC:   csr_rdata = mtvec_q;
            `CSR_MEPC:    csr_rdata = mepc_q;
            `CSR_MCAUSE:  csr_rdata = mcause_q;
            default:      csr_rdata = '0;
        endcase
    end

    // an interrupt wins over whatever op arrives with it
    assign irq_trap  = csr_op_valid && irq_take;
    assign sync_trap = fault_valid ||
                       (csr_op_valid && !irq_take && csr_op == mem_pkg::op_ecall);
    assign do_mret   = csr_op_valid && !irq_take && csr_op == mem_pkg::op_mret;
    assign csr_wr_en = csr_op_valid && !irq_take &&
                       (csr_op == mem_pkg::op_csrrw || csr_op == mem_pkg::op_csrrs);

    assign csr_wr_val = (csr_op == mem_pkg::op_csrrw) ? csr_wdata : (csr_rdata | csr_wdata);

    always_comb begin
        if (irq_trap) begin
            trap_cause = `CAUSE_TIMER_IRQ;
        end else if (fault_valid) begin
            trap_cause = `CAUSE_LOAD_FAULT;
        end else begin
            trap_cause = `CAUSE_ECALL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtvec_q   <= '0;
            mie_q     <= '0;
            mstatus_q <= '0;
        end else if (irq_trap || sync_trap) begin
            mepc_q              <= trap_pc;
            mcause_q            <= trap_cause;
            mstatus_q.f.mpie    <= mstatus_q.f.mie;
            mstatus_q.f.mie     <= 1'b0;
        end else if (do_mret) begin
            mstatus_q.f.mie  <= mstatus_q.f.mpie;
            mstatus_q.f.mpie <= 1'b1;
        end else if (csr_wr_en) begin
            case (csr_addr)
                `CSR_MSTATUS: mstatus_q.raw <= csr_wr_val;
                `CSR_MIE:     mie_q         <= csr_wr_val;
                `CSR_MTVEC:   mtvec_q       <= csr_wr_val;
                `CSR_MEPC:    mepc_q        <= csr_wr_val;
                `CSR_MCAUSE:  mcause_q      <= csr_wr_val;
                default: ;
            endcase
        end
    end

    assign trap_target = mtvec_q;
    assign mret_target = mepc_q;

    // a load fault comes back while busy, never on an acceptance cycle
    no_irq_with_fault: assert property (
        @(posedge clk) disable iff (!rst_n)
        fault_valid |-> !irq_trap
    );

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module mem_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    // request from execute
    input  wire                  req_valid,
    output logic                 req_ready,
    input  wire mem_pkg::op_e    req_op,
    input  wire mem_pkg::size_e  req_size,
    input  wire [`XLEN-1:0]      req_pc,
    input  wire [`XLEN-1:0]      req_src1,
    input  wire [`XLEN-1:0]      req_src2,
    input  wire [11:0]           req_csr_addr,
    // result towards writeback
    output logic                 res_valid,
    output logic [`XLEN-1:0]     res_data,
    output logic                 res_trap,
    output logic [`XLEN-1:0]     res_redirect_pc,
    // AXI4-Lite read master
    output logic [`XLEN-1:0]     araddr,
    output logic [2:0]           arprot,
    output logic                 arvalid,
    input  wire                  arready,
    input  wire [`XLEN-1:0]      rdata,
    input  wire [1:0]            rresp,
    input  wire                  rvalid,
    output logic                 rready,
    // csr unit
    output logic                 csr_op_valid,
    output mem_pkg::op_e         csr_op,
    output logic [11:0]          csr_addr,
    output logic [`XLEN-1:0]     csr_wdata,
    output logic [`XLEN-1:0]     trap_pc,
    output logic                 fault_valid,
    input  wire [`XLEN-1:0]      csr_rdata,
    input  wire [`XLEN-1:0]      trap_target,
    input  wire [`XLEN-1:0]      mret_target,
    input  wire                  irq_take,
    // core-local timer
    output logic                 mmio_rd,
    output logic                 mmio_wr,
    output logic                 mmio_addr_sel,
    output logic [`XLEN-1:0]     mmio_wdata,
    input  wire [`XLEN-1:0]      mmio_rdata
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    logic [1:0]       state;
    logic [1:0]       state_nxt;
    logic [`XLEN-1:0] eff_addr;
    logic             is_clint;
    logic             accept;
    logic             to_axi;

    logic [`XLEN-1:0] addr_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] data_q;
    mem_pkg::size_e   size_q;
    logic             is_load_q;
    logic             trap_q;
    logic             mret_q;

    // pick the addressed bytes and widen them to xlen
    function automatic logic [`XLEN-1:0] extend_load(input mem_pkg::size_e size,
                                                     input logic [`XLEN-1:0] raw);
        logic [`XLEN-1:0] ext;
        case (size)
            mem_pkg::size_b: ext = {{(`XLEN-8){1'b0}}, raw[7:0]};
            mem_pkg::size_h: ext = {{(`XLEN-16){raw[15]}}, raw[15:0]};
            mem_pkg::size_w: ext = {{(`XLEN-32){raw[31]}}, raw[31:0]};
            default:         ext = raw;
        endcase
        return ext;
    endfunction

    assign eff_addr = req_src1 + req_src2;
    assign is_clint = (eff_addr == `CLINT_MTIMECMP_ADDR) || (eff_addr == `CLINT_MTIME_ADDR);

    assign req_ready = state == st_idle;
    assign accept    = req_valid && req_ready;
    // only ordinary loads without a pending interrupt go out on the bus
    assign to_axi    = req_op == mem_pkg::op_load && !is_clint && !irq_take;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_nxt = to_axi ? st_addr : st_done;
                end
            end
            st_addr: begin
                if (arready) begin
                    state_nxt = st_data;
                end
            end
            st_data: begin
                if (rvalid) begin
                    state_nxt = st_done;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            trap_q    <= 1'b0;
            mret_q    <= 1'b0;
            is_load_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                trap_q    <= irq_take || req_op == mem_pkg::op_ecall;
                mret_q    <= !irq_take && req_op == mem_pkg::op_mret;
                is_load_q <= !irq_take && req_op == mem_pkg::op_load;
            end else if (fault_valid) begin
                trap_q <= 1'b1;
            end
        end
    end

    // request payload and the raw result word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= eff_addr;
            pc_q   <= req_pc;
            size_q <= req_size;
            if (irq_take) begin
                data_q <= '0;
            end else if (req_op == mem_pkg::op_load) begin
                // timer value here, bus loads overwrite it on the R beat
                data_q <= mmio_rdata;
            end else if (req_op == mem_pkg::op_csrrw || req_op == mem_pkg::op_csrrs) begin
                data_q <= csr_rdata;
            end else begin
                data_q <= '0;
            end
        end else if (rready && rvalid) begin
            data_q <= fault_valid ? '0 : rdata;
        end
    end

    // read address and data phases
    assign araddr  = addr_q;
    assign arprot  = 3'b000;
    assign arvalid = state == st_addr;
    assign rready  = state == st_data;

    // SLVERR and DECERR both count as a load fault
    assign fault_valid = rready && rvalid && rresp != 2'b00;

    assign res_valid       = state == st_done;
    assign res_trap        = res_valid && trap_q;
    assign res_data        = is_load_q ? extend_load(size_q, data_q) : data_q;
    assign res_redirect_pc = trap_q ? trap_target : (mret_q ? mret_target : '0);

    // csr side sees the live request on the acceptance cycle
    assign csr_op_valid = accept;
    assign csr_op       = req_op;
    assign csr_addr     = req_csr_addr;
    assign csr_wdata    = req_src1;
    assign trap_pc      = req_ready ? req_pc : pc_q;

    // op_clint_store always targets mtimecmp, data rides on src1
    assign mmio_rd       = accept && req_op == mem_pkg::op_load && is_clint;
    assign mmio_wr       = accept && req_op == mem_pkg::op_clint_store && !irq_take;
    assign mmio_addr_sel = eff_addr == `CLINT_MTIME_ADDR;
    assign mmio_wdata    = req_src1;

    // AR must hold until the slave takes it
    ar_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    // after the AR handshake the stage stays busy with no result yet
    no_result_during_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> !req_ready && !res_valid
    );

endmodule

`default_nettype wire

/* logic/mem_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module mem_subsys_top (
    input  wire                  clk,
    input  wire                  rst_n,
    // request
    input  wire                  req_valid,
    output wire                  req_ready,
    input  wire mem_pkg::op_e    req_op,
    input  wire mem_pkg::size_e  req_size,
    input  wire [`XLEN-1:0]      req_pc,
    input  wire [`XLEN-1:0]      req_src1,
    input  wire [`XLEN-1:0]      req_src2,
    input  wire [11:0]           req_csr_addr,
    // result
    output wire                  res_valid,
    output wire [`XLEN-1:0]      res_data,
    output wire                  res_trap,
    output wire [`XLEN-1:0]      res_redirect_pc,
    // AXI4-Lite read
    output wire [`XLEN-1:0]      araddr,
    output wire [2:0]            arprot,
    output wire                  arvalid,
    input  wire                  arready,
    input  wire [`XLEN-1:0]      rdata,
    input  wire [1:0]            rresp,
    input  wire                  rvalid,
    output wire                  rready,
    // gated machine timer interrupt
    output wire                  timer_irq
);

    wire                 csr_op_valid;
    mem_pkg::op_e        csr_op;
    wire [11:0]          csr_addr;
    wire [`XLEN-1:0]     csr_wdata;
    wire [`XLEN-1:0]     trap_pc;
    wire                 fault_valid;
    wire [`XLEN-1:0]     csr_rdata;
    wire [`XLEN-1:0]     trap_target;
    wire [`XLEN-1:0]     mret_target;

    wire                 mmio_rd;
    wire                 mmio_wr;
    wire                 mmio_addr_sel;
    wire [`XLEN-1:0]     mmio_wdata;
    wire [`XLEN-1:0]     mmio_rdata;
    wire                 timer_pending;

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_op          (req_op),
        .req_size        (req_size),
        .req_pc          (req_pc),
        .req_src1        (req_src1),
        .req_src2        (req_src2),
        .req_csr_addr    (req_csr_addr),
        .res_valid       (res_valid),
        .res_data        (res_data),
        .res_trap        (res_trap),
        .res_redirect_pc (res_redirect_pc),
        .araddr          (araddr),
        .arprot          (arprot),
        .arvalid         (arvalid),
        .arready         (arready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready),
        .csr_op_valid    (csr_op_valid),
        .csr_op          (csr_op),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .trap_pc         (trap_pc),
        .fault_valid     (fault_valid),
        .csr_rdata       (csr_rdata),
        .trap_target     (trap_target),
        .mret_target     (mret_target),
        .irq_take        (timer_irq),
        .mmio_rd         (mmio_rd),
        .mmio_wr         (mmio_wr),
        .mmio_addr_sel   (mmio_addr_sel),
        .mmio_wdata      (mmio_wdata),
        .mmio_rdata      (mmio_rdata)
    );

    csr_unit u_csr_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_op_valid  (csr_op_valid),
        .csr_op        (csr_op),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .trap_pc       (trap_pc),
        .fault_valid   (fault_valid),
        .timer_pending (timer_pending),
        .csr_rdata     (csr_rdata),
        .trap_target   (trap_target),
        .mret_target   (mret_target),
        .irq_take      (timer_irq)
    );

    clint_timer u_clint_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_rd       (mmio_rd),
        .mmio_wr       (mmio_wr),
        .mmio_addr_sel (mmio_addr_sel),
        .mmio_wdata    (mmio_wdata),
        .mmio_rdata    (mmio_rdata),
        .timer_pending (timer_pending)
    );

endmodule

`default_nettype wire

/* verif/axi_lite_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module axi_lite_mem_model (
    input  wire              clk,
    input  wire              rst_n,
    input  wire [`XLEN-1:0]  araddr,
    input  wire              arvalid,
    output logic             arready,
    output logic [`XLEN-1:0] rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  wire              rready
);

    logic [31:0] lfsr;
    logic [31:0] lfsr_a;
    logic [31:0] lfsr_b;
    logic [1:0]  rnd;
    logic [1:0]  cnt;
    logic        data_phase;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits per delay draw, one step each
    assign lfsr_a = lfsr_step(lfsr);
    assign lfsr_b = lfsr_step(lfsr_a);
    assign rnd    = {lfsr_a[0], lfsr_b[0]};

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr       <= 32'h52b7_3b17;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rdata      <= '0;
            rresp      <= 2'b00;
            cnt        <= 2'd0;
            data_phase <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready    <= 1'b0;
                data_phase <= 1'b1;
                cnt        <= rnd;
                lfsr       <= lfsr_b;
                // data is the address scrambled, upper region answers SLVERR
                rdata      <= araddr ^ 64'hA5A5_5A5A_0F0F_F0F0;
                rresp      <= (araddr >= 64'h8000_0000) ? 2'b10 : 2'b00;
            end else if (!data_phase && arvalid) begin
                if (cnt == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end else if (data_phase && rvalid && rready) begin
                rvalid     <= 1'b0;
                data_phase <= 1'b0;
                cnt        <= rnd;
                lfsr       <= lfsr_b;
            end else if (data_phase && !rvalid) begin
                if (cnt == 2'd0) begin
                    rvalid <= 1'b1;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_mem_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module tb_mem_subsys;

    localparam int num_reqs     = 70;
    localparam int cycle_budget = 200;
    localparam logic [63:0] data_key = 64'hA5A5_5A5A_0F0F_F0F0;

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    mem_pkg::op_e   req_op;
    mem_pkg::size_e req_size;
    logic [63:0]    req_pc;
    logic [63:0]    req_src1;
    logic [63:0]    req_src2;
    logic [11:0]    req_csr_addr;

    wire            req_ready;
    wire            res_valid;
    wire [63:0]     res_data;
    wire            res_trap;
    wire [63:0]     res_redirect_pc;
    wire [63:0]     araddr;
    wire [2:0]      arprot;
    wire            arvalid;
    wire            arready;
    wire [63:0]     rdata;
    wire [1:0]      rresp;
    wire            rvalid;
    wire            rready;
    wire            timer_irq;

    // reference model state
    logic [63:0] m_mstatus;
    logic [63:0] m_mie;
    logic [63:0] m_mtvec;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [63:0] m_mtimecmp;
    logic [63:0] ref_mtime;

    logic [63:0] exp_data;
    logic        exp_trap;
    logic [63:0] exp_redirect;
    logic        irq_model;
    logic        busy;
    logic        ar_seen;
    logic [31:0] lfsr;
    int          errors;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    mem_subsys_top u_mem_subsys_top (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_size(req_size), .req_pc(req_pc), .req_src1(req_src1),
        .req_src2(req_src2), .req_csr_addr(req_csr_addr),
        .res_valid(res_valid), .res_data(res_data), .res_trap(res_trap),
        .res_redirect_pc(res_redirect_pc),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .timer_irq(timer_irq)
    );

    axi_lite_mem_model u_mem_model (
        .clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid),
        .rready(rready)
    );

    // mirrors the timer count
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_mtime <= '0;
        end else begin
            ref_mtime <= ref_mtime + 64'd1;
        end
    end

    // gated timer interrupt as the model sees it
    assign irq_model = ref_mtime >= m_mtimecmp && m_mstatus[3] && m_mie[7];

    // one request in flight, at most one AR for it
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            ar_seen <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy    <= 1'b1;
            ar_seen <= 1'b0;
        end else begin
            if (res_valid) begin
                busy <= 1'b0;
            end
            if (arvalid && arready) begin
                ar_seen <= 1'b1;
            end
        end
    end

    chk_data: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_data == exp_data)
        else begin
            errors++;
            $display("FAILED %0t: res_data %h, expected %h",
                     $time, $sampled(res_data), exp_data);
        end

    chk_trap: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_trap == exp_trap)
        else begin
            errors++;
            $display("FAILED %0t: res_trap %b, expected %b",
                     $time, $sampled(res_trap), exp_trap);
        end

    chk_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_redirect_pc == exp_redirect)
        else begin
            errors++;
            $display("FAILED %0t: res_redirect_pc %h, expected %h",
                     $time, $sampled(res_redirect_pc), exp_redirect);
        end

    chk_timer_irq: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |-> timer_irq == irq_model)
        else begin
            errors++;
            $display("FAILED %0t: timer_irq %b, expected %b",
                     $time, $sampled(timer_irq), $sampled(irq_model));
        end

    chk_arprot: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arprot == 3'b000)
        else begin
            errors++;
            $display("FAILED %0t: arprot %b, expected 000", $time, $sampled(arprot));
        end

    chk_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> busy)
        else begin
            errors++;
            $display("result appeared with no accepted request at %0t", $time);
        end

    chk_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !req_ready)
        else begin
            errors++;
            $display("stage took a new request while busy at %0t", $time);
        end

    chk_single_ar: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |-> !ar_seen)
        else begin
            errors++;
            $display("second read address issued for one request at %0t", $time);
        end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_rand(input int nbits, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[62:0], lfsr[0]};
        end
    endtask

    // expected load value from the low bytes
    function automatic logic [63:0] widen(input mem_pkg::size_e size, input logic [63:0] w);
        case (size)
            mem_pkg::size_b: return {56'd0, w[7:0]};
            mem_pkg::size_h: return 64'($signed(w[15:0]));
            mem_pkg::size_w: return 64'($signed(w[31:0]));
            default:         return w;
        endcase
    endfunction

    function automatic logic [63:0] csr_value(input logic [11:0] csr);
        case (csr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MIE:     return m_mie;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return '0;
        endcase
    endfunction

    task automatic csr_update(input logic [11:0] csr, input logic [63:0] val);
        case (csr)
            `CSR_MSTATUS: m_mstatus = val;
            `CSR_MIE:     m_mie     = val;
            `CSR_MTVEC:   m_mtvec   = val;
            `CSR_MEPC:    m_mepc    = val;
            `CSR_MCAUSE:  m_mcause  = val;
            default: ;
        endcase
    endtask

    task automatic enter_trap(input logic [63:0] pc, input logic [63:0] cause);
        exp_trap     = 1'b1;
        exp_redirect = m_mtvec;
        m_mepc       = pc;
        m_mcause     = cause;
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
    endtask

    // drive one request, predict its result, wait for it
    task automatic issue(input mem_pkg::op_e op, input mem_pkg::size_e size,
                         input logic [63:0] pc, input logic [63:0] s1,
                         input logic [63:0] s2, input logic [11:0] csr);
        logic [63:0] addr;
        logic [63:0] old;
        logic        irq;
        req_valid    <= 1'b1;
        req_op       <= op;
        req_size     <= size;
        req_pc       <= pc;
        req_src1     <= s1;
        req_src2     <= s2;
        req_csr_addr <= csr;
        do @(posedge clk); while (!req_ready);
        addr         = s1 + s2;
        irq          = ref_mtime >= m_mtimecmp && m_mstatus[3] && m_mie[7];
        exp_data     = '0;
        exp_trap     = 1'b0;
        exp_redirect = '0;
        if (irq) begin
            enter_trap(pc, `CAUSE_TIMER_IRQ);
        end else begin
            case (op)
                mem_pkg::op_load: begin
                    if (addr == `CLINT_MTIME_ADDR) begin
                        exp_data = widen(size, ref_mtime);
                    end else if (addr == `CLINT_MTIMECMP_ADDR) begin
                        exp_data = widen(size, m_mtimecmp);
                    end else if (addr >= 64'h8000_0000) begin
                        enter_trap(pc, `CAUSE_LOAD_FAULT);
                    end else begin
                        exp_data = widen(size, addr ^ data_key);
                    end
                end
                mem_pkg::op_clint_store: m_mtimecmp = s1;
                mem_pkg::op_csrrw, mem_pkg::op_csrrs: begin
                    old      = csr_value(csr);
                    exp_data = old;
                    csr_update(csr, (op == mem_pkg::op_csrrw) ? s1 : (old | s1));
                end
                mem_pkg::op_ecall: enter_trap(pc, `CAUSE_ECALL);
                default: begin
                    exp_redirect = m_mepc;
                    m_mstatus[3] = m_mstatus[7];
                    m_mstatus[7] = 1'b1;
                end
            endcase
        end
        req_valid <= 1'b0;
        do @(posedge clk); while (!res_valid);
    endtask

    task automatic csr_rw(input logic [11:0] csr, input logic [63:0] val);
        issue(mem_pkg::op_csrrw, mem_pkg::size_d, 64'h100, val, '0, csr);
    endtask

    task automatic csr_read(input logic [11:0] csr);
        issue(mem_pkg::op_csrrs, mem_pkg::size_d, 64'h104, '0, '0, csr);
    endtask

    task automatic clint_store(input logic [63:0] val);
        issue(mem_pkg::op_clint_store, mem_pkg::size_d, 64'h200, val, '0, 12'd0);
    endtask

    initial begin
        #(num_reqs * cycle_budget * 10);
        $display("timeout: requests did not complete within the cycle budget");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [63:0] base;
        logic [63:0] offs;
        logic [11:0] csrs [5];
        csrs = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};
        lfsr         = 32'h52b7_3b17;
        errors       = 0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_op       = mem_pkg::op_load;
        req_size     = mem_pkg::size_d;
        req_pc       = '0;
        req_src1     = '0;
        req_src2     = '0;
        req_csr_addr = '0;
        m_mstatus    = '0;
        m_mie        = '0;
        m_mtvec      = '0;
        m_mepc       = '0;
        m_mcause     = '0;
        m_mtimecmp   = '1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // loads of every size below the error region
        for (int i = 0; i < 32; i++) begin
            next_rand(28, base);
            next_rand(8, offs);
            issue(mem_pkg::op_load, mem_pkg::size_e'(i[1:0]), 64'h1000 + 64'(i * 4),
                  base | 64'h1000_0000, offs, 12'd0);
        end

        // write then read back every csr
        for (int i = 0; i < 5; i++) begin
            next_rand(64, base);
            csr_rw(csrs[i], base);
            csr_read(csrs[i]);
        end

        // ecall and mret
        csr_rw(`CSR_MTVEC, 64'h8000_1000);
        csr_rw(`CSR_MSTATUS, 64'h8);
        issue(mem_pkg::op_ecall, mem_pkg::size_d, 64'h400, '0, '0, 12'd0);
        csr_read(`CSR_MCAUSE);
        csr_read(`CSR_MEPC);
        issue(mem_pkg::op_mret, mem_pkg::size_d, 64'h404, '0, '0, 12'd0);
        csr_read(`CSR_MSTATUS);

        // timer reads, compare store and interrupt
        csr_rw(`CSR_MSTATUS, '0);
        issue(mem_pkg::op_load, mem_pkg::size_d, 64'h800, `CLINT_MTIME_ADDR, '0, 12'd0);
        issue(mem_pkg::op_load, mem_pkg::size_d, 64'h804, `CLINT_MTIME_ADDR, '0, 12'd0);
        clint_store(64'h1234_5678);
        issue(mem_pkg::op_load, mem_pkg::size_d, 64'h808, `CLINT_MTIMECMP_ADDR, '0, 12'd0);
        csr_rw(`CSR_MIE, 64'h80);
        clint_store(64'd4);
        issue(mem_pkg::op_csrrs, mem_pkg::size_d, 64'h80c, 64'h8, '0, `CSR_MSTATUS);
        issue(mem_pkg::op_load, mem_pkg::size_d, 64'h900, `CLINT_MTIME_ADDR, '0, 12'd0);
        csr_read(`CSR_MCAUSE);
        csr_read(`CSR_MEPC);
        clint_store('1);
        csr_rw(`CSR_MIE, '0);

        // bus error region
        csr_rw(`CSR_MTVEC, 64'h8000_2000);
        issue(mem_pkg::op_load, mem_pkg::size_w, 64'ha00, 64'h8000_0000, 64'h10, 12'd0);
        csr_read(`CSR_MCAUSE);
        csr_read(`CSR_MEPC);
        issue(mem_pkg::op_load, mem_pkg::size_d, 64'ha04, 64'hffff_0000, '0, 12'd0);

        repeat (2) @(posedge clk);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
logic/mem_pkg.sv
logic/clint_timer.sv
logic/csr_unit.sv
logic/mem_stage.sv
logic/mem_subsys_top.sv
verif/axi_lite_mem_model.sv
verif/tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
    --top-module tb_mem_subsys -o sim_tb_mem_subsys
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_mem_subsys)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1
